// ==== rtl/core_pkg.sv ====
`default_nettype none

package core_pkg;

  localparam int xlen = 64;

  typedef logic [xlen-1:0] reg_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0] reg_addr_t;

  // ld_none marks an instruction that reads no memory
  typedef enum logic [2:0] {
    ld_none = 3'd0,
    lb      = 3'd1,
    lh      = 3'd2,
    lw      = 3'd3,
    ld      = 3'd4,
    lbu     = 3'd5,
    lhu     = 3'd6,
    lwu     = 3'd7
  } load_op_e;

  typedef enum logic [2:0] {
    st_none = 3'd0,
    sb      = 3'd1,
    sh      = 3'd2,
    sw      = 3'd3,
    sd      = 3'd4
  } store_op_e;

endpackage

`default_nettype wire

// ==== rtl/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

  typedef logic [63:0] addr_t;
  typedef logic [7:0] byte_mask_t;

  // bytes per access: 1, 2, 4, 8
  typedef enum logic [1:0] {
    size_b = 2'd0,
    size_h = 2'd1,
    size_w = 2'd2,
    size_d = 2'd3
  } size_e;

  // ram depth in 64-bit words
  localparam int ram_words = 256;
  localparam int ram_index_bits = 8;

endpackage

`default_nettype wire

// ==== rtl/mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage import core_pkg::*, bus_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      ex_valid,
  input  addr_t     ex_pc,
  input  load_op_e  ex_load_op,
  input  store_op_e ex_store_op,
  input  reg_t      ex_result,
  input  reg_t      ex_store_data,
  input  reg_addr_t ex_rd,
  input  logic      ex_rd_we,
  output logic      mem_allowin,
  output logic      wb_valid,
  input  logic      wb_allowin,
  output addr_t     wb_pc,
  output reg_addr_t wb_rd,
  output logic      wb_rd_we,
  output reg_t      wb_data,
  output reg_addr_t fwd_rd,
  output logic      fwd_we,
  output logic      fwd_ready,
  output reg_t      fwd_data,
  output logic      bus_valid,
  input  logic      bus_ready,
  output logic      bus_write,
  output addr_t     bus_addr,
  output size_e     bus_size,
  output reg_t      bus_wdata,
  input  reg_t      bus_rdata
);

  typedef enum logic [1:0] {idle, addr, retn} state_e;

  state_e    state, state_nxt;
  logic      mem_valid;
  load_op_e  load_op_r;
  store_op_e store_op_r;
  addr_t     pc_r;
  reg_t      result_r;
  reg_t      store_data_r;
  reg_addr_t rd_r;
  logic      rd_we_r;
  reg_t      load_data_r;
  logic      accept;
  logic      ex_is_mem;
  logic      is_load;
  logic      is_mem;
  logic      ready_go;
  logic      handshake;

  assign accept    = ex_valid && mem_allowin;
  assign ex_is_mem = (ex_load_op != ld_none) || (ex_store_op != st_none);
  assign is_load   = load_op_r != ld_none;
  assign is_mem    = is_load || (store_op_r != st_none);
  assign handshake = bus_valid && bus_ready;

  // plain alu results pass straight through
  assign ready_go    = !is_mem || (state == retn);
  assign mem_allowin = !mem_valid || (ready_go && wb_allowin);
  assign wb_valid    = mem_valid && ready_go;

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_valid  <= 1'b0;
      state      <= idle;
      load_op_r  <= ld_none;
      store_op_r <= st_none;
    end else begin
      state <= state_nxt;
      if (mem_allowin) begin
        mem_valid <= ex_valid;
      end
      if (accept) begin
        load_op_r  <= ex_load_op;
        store_op_r <= ex_store_op;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      pc_r         <= ex_pc;
      result_r     <= ex_result;
      store_data_r <= ex_store_data;
      rd_r         <= ex_rd;
      rd_we_r      <= ex_rd_we;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      idle: if (accept && ex_is_mem) state_nxt = addr;
      addr: if (handshake) state_nxt = retn;
      retn: begin
        if (accept) begin
          state_nxt = ex_is_mem ? addr : idle;
        end else if (wb_allowin) begin
          state_nxt = idle;
        end
      end
      default: state_nxt = idle;
    endcase
  end

  assign bus_valid = state == addr;
  assign bus_write = store_op_r != st_none;
  assign bus_addr  = result_r;

  always_comb begin
    if (load_op_r == lb || load_op_r == lbu || store_op_r == sb) begin
      bus_size = size_b;
    end else if (load_op_r == lh || load_op_r == lhu || store_op_r == sh) begin
      bus_size = size_h;
    end else if (load_op_r == lw || load_op_r == lwu || store_op_r == sw) begin
      bus_size = size_w;
    end else begin
      bus_size = size_d;
    end
  end

  // only the stored width leaves the stage
  always_comb begin
    case (store_op_r)
      sb:      bus_wdata = {56'b0, store_data_r[7:0]};
      sh:      bus_wdata = {48'b0, store_data_r[15:0]};
      sw:      bus_wdata = {32'b0, store_data_r[31:0]};
      default: bus_wdata = store_data_r;
    endcase
  end

  // ram returns the addressed bytes low-aligned
  always_ff @(posedge clk) begin
    if (handshake) begin
      case (load_op_r)
        lb:      load_data_r <= {{56{bus_rdata[7]}}, bus_rdata[7:0]};
        lh:      load_data_r <= {{48{bus_rdata[15]}}, bus_rdata[15:0]};
        lw:      load_data_r <= {{32{bus_rdata[31]}}, bus_rdata[31:0]};
        lbu:     load_data_r <= {56'b0, bus_rdata[7:0]};
        lhu:     load_data_r <= {48'b0, bus_rdata[15:0]};
        lwu:     load_data_r <= {32'b0, bus_rdata[31:0]};
        default: load_data_r <= bus_rdata;
      endcase
    end
  end

  assign wb_pc    = pc_r;
  assign wb_rd    = rd_r;
  assign wb_rd_we = rd_we_r;
  assign wb_data  = is_load ? load_data_r : result_r;

  assign fwd_rd    = rd_r;
  assign fwd_we    = mem_valid && rd_we_r;
  assign fwd_data  = wb_data;
  // a load forwards nothing until its data is back
  assign fwd_ready = !(mem_valid && is_load) || (state == retn);

  bus_hold_a: assert property (@(posedge clk) disable iff (rst)
    bus_valid && !bus_ready |=> bus_valid &&
      $stable({bus_write, bus_addr, bus_size, bus_wdata}));

  wb_rise_a: assert property (@(posedge clk) disable iff (rst)
    $rose(wb_valid) |-> $past(accept) || $past(handshake));

endmodule

`default_nettype wire

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import core_pkg::*, bus_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  redirect_valid,
  input  addr_t redirect_pc,
  output logic  inst_valid,
  input  logic  inst_allowin,
  output addr_t inst_pc,
  output inst_t inst,
  output logic  bus_valid,
  input  logic  bus_ready,
  output addr_t bus_addr,
  input  reg_t  bus_rdata
);

  addr_t pc_r;
  addr_t req_pc_r;
  logic  pend_r;
  logic  drop_r;
  logic  issue;
  logic  handshake;

  // start a read only when the output slot is free by the handshake
  assign issue     = !pend_r && !redirect_valid && (!inst_valid || inst_allowin);
  assign bus_valid = pend_r || issue;
  assign bus_addr  = pend_r ? req_pc_r : pc_r;
  assign handshake = bus_valid && bus_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_r       <= '0;
      pend_r     <= 1'b0;
      drop_r     <= 1'b0;
      inst_valid <= 1'b0;
    end else begin
      if (handshake) begin
        pend_r <= 1'b0;
        drop_r <= 1'b0;
      end else if (issue) begin
        pend_r <= 1'b1;
      end else if (redirect_valid && pend_r) begin
        drop_r <= 1'b1;
      end

      if (redirect_valid) begin
        pc_r       <= redirect_pc;
        inst_valid <= 1'b0;
      end else if (handshake && !drop_r) begin
        pc_r       <= bus_addr + 64'd4;
        inst_valid <= 1'b1;
      end else if (inst_allowin) begin
        inst_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      req_pc_r <= pc_r;
    end
    if (handshake && !drop_r) begin
      inst_pc <= bus_addr;
      inst    <= bus_rdata[31:0];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/bus_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter import core_pkg::*, bus_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  d_valid,
  output logic  d_ready,
  input  logic  d_write,
  input  addr_t d_addr,
  input  size_e d_size,
  input  reg_t  d_wdata,
  output reg_t  d_rdata,
  input  logic  i_valid,
  output logic  i_ready,
  input  addr_t i_addr,
  output reg_t  i_rdata,
  output logic  ram_valid,
  input  logic  ram_ready,
  output logic  ram_write,
  output addr_t ram_addr,
  output size_e ram_size,
  output reg_t  ram_wdata,
  input  reg_t  ram_rdata
);

  logic busy_r;
  logic grant_r;
  logic last_r;
  logic pick;
  logic grant;
  logic handshake;

  // grant 1 is the fetch port
  // fetch wins a tie only when data was served last
  assign pick  = i_valid && (!d_valid || !last_r);
  assign grant = busy_r ? grant_r : pick;

  assign ram_valid = grant ? i_valid : d_valid;
  assign ram_write = grant ? 1'b0 : d_write;
  assign ram_addr  = grant ? i_addr : d_addr;
  assign ram_size  = grant ? size_w : d_size;
  assign ram_wdata = grant ? '0 : d_wdata;

  assign d_ready = !grant && ram_ready;
  assign i_ready = grant && ram_ready;
  assign d_rdata = grant ? '0 : ram_rdata;
  assign i_rdata = grant ? ram_rdata : '0;

  assign handshake = ram_valid && ram_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_r  <= 1'b0;
      grant_r <= 1'b0;
      last_r  <= 1'b0;
    end else if (handshake) begin
      busy_r <= 1'b0;
      last_r <= grant;
    end else if (ram_valid) begin
      // hold this port until its transfer completes
      busy_r  <= 1'b1;
      grant_r <= grant;
    end
  end

  // a waiting transfer keeps its port until ready
  grant_hold_a: assert property (@(posedge clk) disable iff (rst)
    ram_valid && !ram_ready |=> grant == $past(grant));

endmodule

`default_nettype wire

// ==== rtl/data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_ram import core_pkg::*, bus_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  ram_valid,
  output logic  ram_ready,
  input  logic  ram_write,
  input  addr_t ram_addr,
  input  size_e ram_size,
  input  reg_t  ram_wdata,
  output reg_t  ram_rdata
);

  reg_t mem [ram_words];

  logic [ram_index_bits-1:0] index;
  logic [5:0]                bit_shift;
  byte_mask_t                size_mask;
  byte_mask_t                lane_mask;
  reg_t                      wdata_shifted;

  assign index     = ram_addr[ram_index_bits+2:3];
  assign bit_shift = {ram_addr[2:0], 3'b000};

  always_comb begin
    case (ram_size)
      size_b:  size_mask = 8'h01;
      size_h:  size_mask = 8'h03;
      size_w:  size_mask = 8'h0f;
      default: size_mask = 8'hff;
    endcase
  end

  assign lane_mask     = size_mask << ram_addr[2:0];
  assign wdata_shifted = ram_wdata << bit_shift;

  // ready one cycle after valid, dropped after the handshake
  always_ff @(posedge clk) begin
    if (rst) begin
      ram_ready <= 1'b0;
    end else begin
      ram_ready <= ram_valid && !ram_ready;
    end
  end

  always_ff @(posedge clk) begin
    if (ram_valid && !ram_ready) begin
      ram_rdata <= mem[index] >> bit_shift;
    end
    if (ram_valid && ram_ready && ram_write) begin
      for (int i = 0; i < 8; i++) begin
        if (lane_mask[i]) begin
          mem[index][i*8 +: 8] <= wdata_shifted[i*8 +: 8];
        end
      end
    end
  end

  addr_range_a: assert property (@(posedge clk) disable iff (rst)
    ram_valid |-> (ram_addr >> 3) < ram_words);

endmodule

`default_nettype wire

// ==== rtl/mem_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem import core_pkg::*, bus_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      ex_valid,
  input  addr_t     ex_pc,
  input  load_op_e  ex_load_op,
  input  store_op_e ex_store_op,
  input  reg_t      ex_result,
  input  reg_t      ex_store_data,
  input  reg_addr_t ex_rd,
  input  logic      ex_rd_we,
  output logic      mem_allowin,
  output logic      wb_valid,
  input  logic      wb_allowin,
  output addr_t     wb_pc,
  output reg_addr_t wb_rd,
  output logic      wb_rd_we,
  output reg_t      wb_data,
  output reg_addr_t fwd_rd,
  output logic      fwd_we,
  output logic      fwd_ready,
  output reg_t      fwd_data,
  input  logic      redirect_valid,
  input  addr_t     redirect_pc,
  output logic      inst_valid,
  input  logic      inst_allowin,
  output addr_t     inst_pc,
  output inst_t     inst
);

  logic  d_valid, d_ready, d_write;
  addr_t d_addr;
  size_e d_size;
  reg_t  d_wdata, d_rdata;
  logic  i_valid, i_ready;
  addr_t i_addr;
  reg_t  i_rdata;
  logic  ram_valid, ram_ready, ram_write;
  addr_t ram_addr;
  size_e ram_size;
  reg_t  ram_wdata, ram_rdata;

  mem_stage mem_stage0 (
    .clk, .rst, .ex_valid, .ex_pc, .ex_load_op, .ex_store_op, .ex_result,
    .ex_store_data, .ex_rd, .ex_rd_we, .mem_allowin, .wb_valid, .wb_allowin,
    .wb_pc, .wb_rd, .wb_rd_we, .wb_data, .fwd_rd, .fwd_we, .fwd_ready, .fwd_data,
    .bus_valid(d_valid), .bus_ready(d_ready), .bus_write(d_write),
    .bus_addr(d_addr), .bus_size(d_size), .bus_wdata(d_wdata), .bus_rdata(d_rdata)
  );

  fetch_unit fetch0 (
    .clk, .rst, .redirect_valid, .redirect_pc, .inst_valid, .inst_allowin,
    .inst_pc, .inst, .bus_valid(i_valid), .bus_ready(i_ready),
    .bus_addr(i_addr), .bus_rdata(i_rdata)
  );

  bus_arbiter arb0 (
    .clk, .rst, .d_valid, .d_ready, .d_write, .d_addr, .d_size, .d_wdata, .d_rdata,
    .i_valid, .i_ready, .i_addr, .i_rdata, .ram_valid, .ram_ready, .ram_write,
    .ram_addr, .ram_size, .ram_wdata, .ram_rdata
  );

  data_ram ram0 (
    .clk, .rst, .ram_valid, .ram_ready, .ram_write, .ram_addr, .ram_size,
    .ram_wdata, .ram_rdata
  );

endmodule

`default_nettype wire

// ==== testbench/tb_mem_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem import core_pkg::*, bus_pkg::*; ();

  localparam int max_entries = 128;
  localparam int timeout_cycles = 400;
  localparam int fetch_words = 16;
  localparam addr_t fetch_base = 64'h200;

  logic      clk;
  logic      rst;
  logic      ex_valid;
  addr_t     ex_pc;
  load_op_e  ex_load_op;
  store_op_e ex_store_op;
  reg_t      ex_result;
  reg_t      ex_store_data;
  reg_addr_t ex_rd;
  logic      ex_rd_we;
  logic      mem_allowin;
  logic      wb_valid;
  logic      wb_allowin;
  addr_t     wb_pc;
  reg_addr_t wb_rd;
  logic      wb_rd_we;
  reg_t      wb_data;
  reg_addr_t fwd_rd;
  logic      fwd_we;
  logic      fwd_ready;
  reg_t      fwd_data;
  logic      redirect_valid;
  addr_t     redirect_pc;
  logic      inst_valid;
  logic      inst_allowin;
  addr_t     inst_pc;
  inst_t     inst;

  // stimulus table: ex_result column doubles as the address
  load_op_e  t_load [max_entries];
  store_op_e t_store [max_entries];
  addr_t     t_addr [max_entries];
  reg_t      t_data [max_entries];
  reg_t      t_exp [max_entries];
  int        n_entries;
  int        fetch_mark;

  logic [7:0] shadow [2048];
  load_op_e   sgn_list [3] = '{lb, lh, lw};
  load_op_e   uns_list [3] = '{lbu, lhu, lwu};
  store_op_e  st_list [4] = '{sb, sh, sw, sd};

  int    seed = 32'h791068de;
  int    errors;
  int    timeouts;
  int    sent_count;
  int    wb_count;
  int    inst_count;
  logic  stall_en;
  logic  fetch_on;
  addr_t inst_exp_pc;

  mem_subsystem dut0 (
    .clk, .rst, .ex_valid, .ex_pc, .ex_load_op, .ex_store_op, .ex_result,
    .ex_store_data, .ex_rd, .ex_rd_we, .mem_allowin, .wb_valid, .wb_allowin,
    .wb_pc, .wb_rd, .wb_rd_we, .wb_data, .fwd_rd, .fwd_we, .fwd_ready, .fwd_data,
    .redirect_valid, .redirect_pc, .inst_valid, .inst_allowin, .inst_pc, .inst
  );

  always #5 clk = ~clk;

  task automatic compare_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_and_finish();
    $display("errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  endtask

  task automatic abort_on_timeout(input string msg);
    timeouts++;
    $display("Timeout at %0t: %s", $time, msg);
    report_and_finish();
  endtask

  function automatic int op_bytes(input load_op_e lop, input store_op_e sop);
    if (sop != st_none) begin
      case (sop)
        sb:      return 1;
        sh:      return 2;
        sw:      return 4;
        default: return 8;
      endcase
    end
    case (lop)
      lb, lbu: return 1;
      lh, lhu: return 2;
      lw, lwu: return 4;
      default: return 8;
    endcase
  endfunction

  function automatic reg_t fill_word(input addr_t a);
    return {a[31:0] ^ a[63:32] ^ 32'hc3a5_9e17, ~a[31:0] + 32'h1357_9bdf};
  endfunction

  // little-endian instruction word from the shadow bytes
  function automatic inst_t shadow_inst(input addr_t a);
    logic [10:0] b;
    b = a[10:0];
    return {shadow[b + 11'd3], shadow[b + 11'd2], shadow[b + 11'd1], shadow[b]};
  endfunction

  // expected value follows the shadow memory in table order
  task automatic add_entry(input load_op_e lop, input store_op_e sop, input addr_t a,
                           input reg_t d);
    int          nb;
    reg_t        v;
    logic [10:0] base;
    nb = op_bytes(lop, sop);
    base = a[10:0];
    v = a;
    if (sop != st_none) begin
      for (int i = 0; i < nb; i++) begin
        shadow[base + 11'(i)] = d[8*i +: 8];
      end
    end else if (lop != ld_none) begin
      v = '0;
      for (int i = 0; i < nb; i++) begin
        v[8*i +: 8] = shadow[base + 11'(i)];
      end
      if ((lop == lb || lop == lh || lop == lw) && v[8*nb-1]) begin
        for (int j = 8 * nb; j < 64; j++) begin
          v[j] = 1'b1;
        end
      end
    end
    t_load[n_entries]  = lop;
    t_store[n_entries] = sop;
    t_addr[n_entries]  = a;
    t_data[n_entries]  = d;
    t_exp[n_entries]   = v;
    n_entries++;
  endtask

  task automatic ext_loads(input addr_t a, input reg_t w);
    int sz;
    add_entry(ld_none, sd, a, w);
    for (int s = 0; s < 3; s++) begin
      sz = 1 << s;
      for (int o = 0; o < 8; o += sz) begin
        add_entry(sgn_list[s], st_none, a + 64'(o), '0);
        add_entry(uns_list[s], st_none, a + 64'(o), '0);
      end
    end
  endtask

  task automatic build_table();
    addr_t base;
    int    sz;
    for (int k = 0; k < 4; k++) begin
      base = 64'h100 + 64'(8 * k);
      add_entry(ld_none, sd, base, fill_word(base));
    end
    add_entry(ld_none, st_none, 64'h0123_4567_89ab_cdef, '0);
    add_entry(ld_none, st_none, 64'hfedc_ba98_7654_3210, '0);
    // every size at every aligned offset, then the whole word
    for (int s = 0; s < 4; s++) begin
      base = 64'h100 + 64'(8 * s);
      sz = 1 << s;
      for (int o = 0; o < 8; o += sz) begin
        add_entry(ld_none, st_list[s], base + 64'(o), {$random(seed), $random(seed)});
        add_entry(ld, st_none, base, '0);
      end
    end
    ext_loads(64'h140, 64'hf081_7f00_a55a_c33c);
    for (int k = 0; k < fetch_words / 2; k++) begin
      base = fetch_base + 64'(8 * k);
      add_entry(ld_none, sd, base, fill_word(base));
    end
    // entries from here on run while the fetcher competes for the ram
    fetch_mark = n_entries;
    ext_loads(64'h148, 64'h807f_ff01_7ffe_8000);
    add_entry(ld_none, st_none, 64'h5555_aaaa_0f0f_f0f0, '0);
    add_entry(ld_none, st_none, 64'h8000_0000_0000_0001, '0);
  endtask

  task automatic send_entry(input int k);
    int waited;
    @(negedge clk);
    ex_valid      = 1'b1;
    ex_pc         = 64'h1000 + 64'(4 * k);
    ex_load_op    = t_load[k];
    ex_store_op   = t_store[k];
    ex_result     = t_addr[k];
    ex_store_data = t_data[k];
    ex_rd         = 5'(k % 31 + 1);
    ex_rd_we      = t_store[k] == st_none;
    sent_count    = k + 1;
    #2;
    waited = 0;
    while (!mem_allowin && waited < timeout_cycles) begin
      @(negedge clk);
      #2;
      waited++;
    end
    if (!mem_allowin) begin
      abort_on_timeout("memory stage never accepted the instruction");
    end else begin
      @(negedge clk);
      ex_valid = 1'b0;
    end
  endtask

  task automatic wait_writeback(input int n);
    int waited;
    waited = 0;
    while (wb_count < n && waited < timeout_cycles) begin
      @(negedge clk);
      #2;
      waited++;
    end
    if (wb_count < n) begin
      abort_on_timeout("instruction never reached write-back");
    end
  endtask

  task automatic start_fetch();
    @(negedge clk);
    redirect_valid = 1'b1;
    redirect_pc    = fetch_base;
    inst_exp_pc    = fetch_base;
    fetch_on       = 1'b1;
    @(negedge clk);
    redirect_valid = 1'b0;
  endtask

  // random back-pressure on both output handshakes
  always @(negedge clk) begin
    if (stall_en) begin
      wb_allowin = ($random(seed) & 3) != 0;
    end else begin
      wb_allowin = 1'b1;
    end
    inst_allowin = fetch_on && (inst_count < fetch_words) && (($random(seed) & 7) != 0);
  end

  // transfers happen at the next rising edge when sampled here
  always @(negedge clk) begin
    #1;
    if (!rst && wb_valid) begin
      compare_value("fwd_ready", 64'(fwd_ready), 64'd1);
      compare_value("fwd_we", 64'(fwd_we), 64'(wb_rd_we));
      compare_value("fwd_rd", 64'(fwd_rd), 64'(wb_rd));
      compare_value("fwd_data", fwd_data, wb_data);
    end
    // a held load still waiting for its data
    if (!rst && fwd_we && !wb_valid) begin
      compare_value("fwd_ready while load pending", 64'(fwd_ready), 64'd0);
    end
    if (!rst && wb_valid && wb_allowin) begin
      compare_value("write-back within sent entries", 64'(wb_count < sent_count), 64'd1);
      if (wb_count < sent_count) begin
        compare_value("wb_pc", wb_pc, 64'h1000 + 64'(4 * wb_count));
        compare_value("wb_rd", 64'(wb_rd), 64'(wb_count % 31 + 1));
        compare_value("wb_rd_we", 64'(wb_rd_we), 64'(t_store[wb_count] == st_none));
        compare_value("wb_data", wb_data, t_exp[wb_count]);
      end
      wb_count++;
    end
    if (!rst && fetch_on && !redirect_valid && inst_valid && inst_allowin) begin
      compare_value("inst_pc", inst_pc, inst_exp_pc);
      compare_value("inst", 64'(inst), 64'(shadow_inst(inst_exp_pc)));
      inst_exp_pc = inst_exp_pc + 64'd4;
      inst_count++;
    end
  end

  initial begin
    int waited;
    clk            = 1'b0;
    rst            = 1'b1;
    ex_valid       = 1'b0;
    ex_pc          = '0;
    ex_load_op     = ld_none;
    ex_store_op    = st_none;
    ex_result      = '0;
    ex_store_data  = '0;
    ex_rd          = '0;
    ex_rd_we       = 1'b0;
    wb_allowin     = 1'b1;
    redirect_valid = 1'b0;
    redirect_pc    = '0;
    inst_allowin   = 1'b0;
    errors         = 0;
    timeouts       = 0;
    sent_count     = 0;
    wb_count       = 0;
    inst_count     = 0;
    stall_en       = 1'b0;
    fetch_on       = 1'b0;
    inst_exp_pc    = '0;
    n_entries      = 0;
    build_table();

    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    #2;
    compare_value("wb_valid after reset", 64'(wb_valid), 64'd0);
    compare_value("inst_valid after reset", 64'(inst_valid), 64'd0);
    compare_value("fwd_we after reset", 64'(fwd_we), 64'd0);
    compare_value("mem_allowin after reset", 64'(mem_allowin), 64'd1);

    stall_en = 1'b1;
    for (int k = 0; k < n_entries && timeouts == 0; k++) begin
      if (k == fetch_mark) begin
        start_fetch();
      end
      send_entry(k);
      if (timeouts == 0) begin
        wait_writeback(k + 1);
      end
    end

    if (timeouts == 0) begin
      waited = 0;
      while (inst_count < fetch_words && waited < timeout_cycles) begin
        @(negedge clk);
        #2;
        waited++;
      end
      if (inst_count < fetch_words) begin
        abort_on_timeout("fetch unit stopped delivering instruction words");
      end else begin
        // a duplicated write-back would show up here
        repeat (4) @(negedge clk);
        compare_value("write-back count", 64'(wb_count), 64'(n_entries));
        report_and_finish();
      end
    end
  end

endmodule

`default_nettype wire

// ==== compile.f ====
rtl/core_pkg.sv
rtl/bus_pkg.sv
rtl/mem_stage.sv
rtl/fetch_unit.sv
rtl/bus_arbiter.sv
rtl/data_ram.sv
rtl/mem_subsystem.sv
testbench/tb_mem_subsystem.sv

// ==== Makefile ====
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module mem_subsystem

sim:
	verilator --binary --timing --assert -f compile.f --top-module tb_mem_subsystem \
		-Mdir obj_dir -o tb_mem_subsystem
	./obj_dir/tb_mem_subsystem | tee sim.log
	grep -q "^Simulation PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
